//--- common/lcd_pkg.sv
package lcd_pkg;

    // bus and request widths
    localparam int LCD_BYTE_W  = 8;
    localparam int LCD_FUNC_W  = 4;
    localparam int INIT_STEP_W = 3;
    // wide enough for 15 ms at 50 MHz
    localparam int DELAY_W     = 20;

    // one byte on the lcd data bus
    typedef logic [LCD_BYTE_W-1:0] lcd_byte_t;

    // requested operation
    typedef logic [LCD_FUNC_W-1:0] lcd_func_t;

    // index into the init command table
    typedef logic [INIT_STEP_W-1:0] init_step_t;

    // clock-cycle count for a delay
    typedef logic [DELAY_W-1:0] delay_t;

    // function codes, 4 to 15 do nothing
    localparam lcd_func_t FUNC_INIT      = 4'd0;
    localparam lcd_func_t FUNC_SETCURSOR = 4'd1;
    localparam lcd_func_t FUNC_CMD       = 4'd2;
    localparam lcd_func_t FUNC_DATA      = 4'd3;

    // which wait the timer runs
    typedef enum logic [2:0] {
        // 15 ms after power-up
        DLY_POWERUP,
        // 4.1 ms after first function set
        DLY_INIT_FIRST,
        // 100 us after second and third function set
        DLY_INIT_NEXT,
        // 37 us, normal execution time
        DLY_EXEC,
        // 1.52 ms, clear and return home
        DLY_CLEAR,
        // width of the E pulse
        DLY_PULSE
    } delay_class_e;

    // how the bus driver forms the byte
    typedef enum logic [1:0] {
        SRC_INIT,
        SRC_CURSOR,
        SRC_CMD,
        SRC_DATA
    } byte_src_e;

    // HD44780 instruction bytes
    localparam lcd_byte_t CMD_CLEAR_DISPLAY  = 8'h01;
    localparam lcd_byte_t CMD_RETURN_HOME    = 8'h02;
    // increment address, no display shift
    localparam lcd_byte_t CMD_ENTRY_INCREASE = 8'h06;
    localparam lcd_byte_t CMD_DISPLAY_OFF    = 8'h08;
    // display on, cursor off
    localparam lcd_byte_t CMD_DISPLAY_ON     = 8'h0C;
    // 8-bit bus, 2 lines, 5x8 font
    localparam lcd_byte_t CMD_FUNCTION_SET   = 8'h38;
    // ddram address of line 1 and line 2
    localparam lcd_byte_t CMD_LINE_1         = 8'h80;
    localparam lcd_byte_t CMD_LINE_2         = 8'hC0;

    // bytes in the power-up sequence
    localparam int INIT_CMD_COUNT = 8;

endpackage

//--- common/lcd_seq_if.sv
interface lcd_seq_if;

    // one-cycle strobe, driver captures byte and rs
    logic                   load;
    // how to build the byte
    lcd_pkg::byte_src_e     src;
    // init table index
    lcd_pkg::init_step_t    step;
    // latched request byte
    lcd_pkg::lcd_byte_t     arg;
    // level, registered into E
    logic                   e_high;

    modport seq (
        output load,
        output src,
        output step,
        output arg,
        output e_high
    );

    modport drv (
        input load,
        input src,
        input step,
        input arg,
        input e_high
    );

endinterface

//--- dv/lcd_ref_model.svh
`ifndef LCD_REF_MODEL_SVH
`define LCD_REF_MODEL_SVH

// expected transfers of the operation under test
lcd_pkg::lcd_byte_t exp_bytes[$];
logic               exp_rs[$];
lcd_pkg::delay_t    exp_gap[$];

// HD44780 power-up order
function automatic lcd_pkg::lcd_byte_t init_table_byte(input int step);
    case (step)
        0, 1, 2: return lcd_pkg::CMD_FUNCTION_SET;
        3: return lcd_pkg::CMD_DISPLAY_OFF;
        4: return lcd_pkg::CMD_CLEAR_DISPLAY;
        5: return lcd_pkg::CMD_RETURN_HOME;
        6: return lcd_pkg::CMD_ENTRY_INCREASE;
        default: return lcd_pkg::CMD_DISPLAY_ON;
    endcase
endfunction

// line 1 or line 2 ddram address, anything else homes to line 1
function automatic lcd_pkg::lcd_byte_t cursor_address(input lcd_pkg::lcd_byte_t arg);
    if (arg[7:4] == 4'h0) begin
        return lcd_pkg::CMD_LINE_1 | {4'h0, arg[3:0]};
    end
    if (arg[7:4] == 4'h1) begin
        return lcd_pkg::CMD_LINE_2 | {4'h0, arg[3:0]};
    end
    return lcd_pkg::CMD_LINE_1;
endfunction

// shortest wait allowed after a byte, init_step below zero outside init
function automatic lcd_pkg::delay_t min_gap_after(
    input lcd_pkg::lcd_byte_t b,
    input logic               is_cmd,
    input int                 init_step
);
    if (init_step == 0) begin
        return INIT_FIRST_CYCLES;
    end
    if (init_step == 1 || init_step == 2) begin
        return INIT_NEXT_CYCLES;
    end
    // clear and home are the slow instructions
    if (is_cmd && (b == lcd_pkg::CMD_CLEAR_DISPLAY || b == lcd_pkg::CMD_RETURN_HOME)) begin
        return CLEAR_CYCLES;
    end
    return EXEC_CYCLES;
endfunction

task automatic build_expected(input lcd_pkg::lcd_func_t func, input lcd_pkg::lcd_byte_t arg);
    lcd_pkg::lcd_byte_t b;
    exp_bytes.delete();
    exp_rs.delete();
    exp_gap.delete();
    if (func == lcd_pkg::FUNC_INIT) begin
        for (int i = 0; i < lcd_pkg::INIT_CMD_COUNT; i++) begin
            b = init_table_byte(i);
            exp_bytes.push_back(b);
            exp_rs.push_back(1'b0);
            exp_gap.push_back(min_gap_after(b, 1'b1, i));
        end
    end else begin
        b = (func == lcd_pkg::FUNC_SETCURSOR) ? cursor_address(arg) : arg;
        exp_bytes.push_back(b);
        // only data writes select the data register
        exp_rs.push_back(func == lcd_pkg::FUNC_DATA);
        exp_gap.push_back(min_gap_after(b, func != lcd_pkg::FUNC_DATA, -1));
    end
endtask

`endif

//--- dv/tb_lcd_ctrl.sv
module tb_lcd_ctrl;

    // short delays so a full init takes a few hundred cycles
    localparam lcd_pkg::delay_t POWERUP_CYCLES    = 20'd40;
    localparam lcd_pkg::delay_t INIT_FIRST_CYCLES = 20'd25;
    localparam lcd_pkg::delay_t INIT_NEXT_CYCLES  = 20'd12;
    localparam lcd_pkg::delay_t EXEC_CYCLES       = 20'd6;
    localparam lcd_pkg::delay_t CLEAR_CYCLES      = 20'd18;
    localparam lcd_pkg::delay_t PULSE_CYCLES      = 20'd3;
    localparam int OP_TIMEOUT   = 150;
    localparam int INIT_TIMEOUT = 600;
    localparam int QUIET_CYCLES = 80;

    logic               i_clk = 1'b0;
    logic               i_rst_n;
    logic               i_en_lcd;
    logic               i_lcd_blon;
    lcd_pkg::lcd_byte_t i_data;
    lcd_pkg::lcd_func_t i_func;
    lcd_pkg::lcd_byte_t o_lcd_data;
    logic               o_lcd_e;
    logic               o_lcd_rw;
    logic               o_lcd_rs;
    logic               o_lcd_on;
    logic               o_lcd_blon;
    logic               o_done_lcd;

    logic [31:0]        lfsr_state = 32'h895f_4f2b;
    int                 errors = 0;
    int                 checks = 0;
    int                 tests = 0;
    int                 failed_tests = 0;
    int                 test_err_base = 0;

    // bus monitor record appended at each negedge
    lcd_pkg::lcd_byte_t mon_bytes[$];
    logic               mon_rs[$];
    lcd_pkg::delay_t    mon_width[$];
    lcd_pkg::delay_t    mon_gap[$];
    int                 rise_cycles[$];
    int                 cycle_cnt = 0;
    int                 rise_count = 0;
    int                 done_count = 0;
    logic               e_prev = 1'b0;
    logic               in_gap = 1'b0;
    lcd_pkg::delay_t    width_cnt = '0;
    lcd_pkg::delay_t    gap_cnt = '0;

    `include "lcd_ref_model.svh"

    always #10 i_clk = ~i_clk;

    lcd_ctrl_top #(
        .P_DLY_POWERUP    (POWERUP_CYCLES),
        .P_DLY_INIT_FIRST (INIT_FIRST_CYCLES),
        .P_DLY_INIT_NEXT  (INIT_NEXT_CYCLES),
        .P_DLY_EXEC       (EXEC_CYCLES),
        .P_DLY_CLEAR      (CLEAR_CYCLES),
        .P_DLY_PULSE      (PULSE_CYCLES)
    ) uut (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_en_lcd   (i_en_lcd),
        .i_lcd_blon (i_lcd_blon),
        .i_data     (i_data),
        .i_func     (i_func),
        .o_lcd_data (o_lcd_data),
        .o_lcd_e    (o_lcd_e),
        .o_lcd_rw   (o_lcd_rw),
        .o_lcd_rs   (o_lcd_rs),
        .o_lcd_on   (o_lcd_on),
        .o_lcd_blon (o_lcd_blon),
        .o_done_lcd (o_done_lcd)
    );

    // gap runs from E fall up to the next rise or up to and including done
    always @(negedge i_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (i_rst_n) begin
            if (o_lcd_e && !e_prev) begin
                rise_count = rise_count + 1;
                rise_cycles.push_back(cycle_cnt);
                if (in_gap) begin
                    mon_gap.push_back(gap_cnt);
                end
                in_gap    = 1'b0;
                width_cnt = 20'd1;
            end else if (o_lcd_e) begin
                width_cnt = width_cnt + 1'b1;
            end else if (e_prev) begin
                // falling edge latches the byte into the lcd
                mon_bytes.push_back(o_lcd_data);
                mon_rs.push_back(o_lcd_rs);
                mon_width.push_back(width_cnt);
                in_gap  = 1'b1;
                gap_cnt = 20'd1;
            end else if (in_gap) begin
                gap_cnt = gap_cnt + 1'b1;
            end
            if (o_done_lcd) begin
                done_count = done_count + 1;
                if (in_gap) begin
                    mon_gap.push_back(gap_cnt);
                end
                in_gap = 1'b0;
            end
            // aborted operation leaves no gap behind
            if (!i_en_lcd) begin
                in_gap = 1'b0;
            end
            e_prev = o_lcd_e;
        end
    end

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors != test_err_base) begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - test_err_base);
        end else begin
            $display("test %s: ok", name);
        end
        test_err_base = errors;
    endtask

    task automatic wait_rises(input int n, input int limit, output bit ok);
        int t;
        t = 0;
        while (rise_count < n && t < limit) begin
            @(posedge i_clk);
            t++;
        end
        ok = (rise_count >= n);
    endtask

    task automatic wait_done(input int n, input int limit, output bit ok);
        int t;
        t = 0;
        while (done_count < n && t < limit) begin
            @(posedge i_clk);
            t++;
        end
        ok = (done_count >= n);
    endtask

    // one request and then a compare of the bus record with the model
    task automatic run_op(
        input lcd_pkg::lcd_func_t func,
        input lcd_pkg::lcd_byte_t arg,
        input int                 limit
    );
        int byte_base;
        int gap_base;
        int rise_base;
        int done_base;
        int req_cycle;
        int n;
        bit ok;
        build_expected(func, arg);
        @(posedge i_clk);
        byte_base = mon_bytes.size();
        gap_base  = mon_gap.size();
        rise_base = rise_count;
        done_base = done_count;
        req_cycle = cycle_cnt;
        i_func <= func;
        i_data <= arg;
        wait_rises(rise_base + 1, limit, ok);
        if (!ok) begin
            errors++;
            $display("timeout: no E pulse for function %0d at %0t", func, $time);
        end
        // request is latched so park the code on a no-op
        @(posedge i_clk);
        i_func <= 4'hF;
        wait_done(done_base + 1, limit, ok);
        if (!ok) begin
            errors++;
            $display("timeout: no done pulse for function %0d at %0t", func, $time);
        end
        // a few more cycles to catch a stray E or a second done
        repeat (4) @(posedge i_clk);
        if (func == lcd_pkg::FUNC_INIT && rise_cycles.size() > rise_base) begin
            check_value($sformatf("power-up wait %0d cycles", rise_cycles[rise_base] - req_cycle),
                32'(rise_cycles[rise_base] - req_cycle >= int'(POWERUP_CYCLES)), 1);
        end
        check_value("byte count", mon_bytes.size() - byte_base, exp_bytes.size());
        check_value("done pulses", done_count - done_base, 1);
        n = mon_bytes.size() - byte_base;
        if (n > exp_bytes.size()) begin
            n = exp_bytes.size();
        end
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("byte %0d", i), 32'(mon_bytes[byte_base + i]),
                32'(exp_bytes[i]));
            check_value($sformatf("rs of byte %0d", i), 32'(mon_rs[byte_base + i]),
                32'(exp_rs[i]));
            check_value($sformatf("E width of byte %0d", i), 32'(mon_width[byte_base + i]),
                32'(PULSE_CYCLES));
            if (gap_base + i < mon_gap.size()) begin
                check_value($sformatf("gap %0d after byte %0d, minimum %0d",
                    mon_gap[gap_base + i], i, exp_gap[i]),
                    32'(mon_gap[gap_base + i] >= exp_gap[i]), 1);
            end
        end
    endtask

    initial begin
        logic [31:0]        v;
        lcd_pkg::lcd_byte_t arg;
        lcd_pkg::lcd_func_t code;
        int                 base_rise;
        int                 base_done;
        int                 t;
        bit                 ok;
        i_rst_n    = 1'b0;
        i_en_lcd   = 1'b0;
        i_lcd_blon = 1'b0;
        i_data     = 8'h00;
        i_func     = 4'hF;
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;

        // outputs quiet after reset and pass-through wires follow
        @(negedge i_clk);
        check_value("E after reset", 32'(o_lcd_e), 0);
        check_value("RS after reset", 32'(o_lcd_rs), 0);
        check_value("DATA after reset", 32'(o_lcd_data), 0);
        check_value("RW after reset", 32'(o_lcd_rw), 0);
        check_value("done after reset", 32'(o_done_lcd), 0);
        check_value("lcd_on follows enable", 32'(o_lcd_on), 0);
        check_value("blon follows input", 32'(o_lcd_blon), 0);
        take_bits(1, v);
        @(posedge i_clk);
        i_en_lcd   <= 1'b1;
        i_lcd_blon <= v[0];
        @(negedge i_clk);
        check_value("lcd_on follows enable", 32'(o_lcd_on), 1);
        check_value("blon follows input", 32'(o_lcd_blon), 32'(v[0]));
        end_test("reset values");

        run_op(lcd_pkg::FUNC_INIT, 8'h00, INIT_TIMEOUT);
        end_test("init sequence");

        // bias towards line 1 and line 2 with some out of range
        repeat (8) begin
            take_bits(2, v);
            code = v[3:0];
            take_bits(8, v);
            arg = v[7:0];
            if (code[1:0] == 2'd0) begin
                arg[7:4] = 4'h0;
            end else if (code[1:0] == 2'd1) begin
                arg[7:4] = 4'h1;
            end
            run_op(lcd_pkg::FUNC_SETCURSOR, arg, OP_TIMEOUT);
        end
        end_test("set cursor");

        repeat (12) begin
            take_bits(3, v);
            code = v[0] ? lcd_pkg::FUNC_DATA : lcd_pkg::FUNC_CMD;
            // one in four is clear or home
            ok = (v[2:1] == 2'd0);
            take_bits(8, v);
            arg = v[7:0];
            if (ok) begin
                arg = v[0] ? lcd_pkg::CMD_RETURN_HOME : lcd_pkg::CMD_CLEAR_DISPLAY;
            end
            run_op(code, arg, OP_TIMEOUT);
        end
        end_test("command and data writes");

        repeat (4) begin
            take_bits(4, v);
            code = v[3:0];
            if (code < 4'd4) begin
                code = code + 4'd4;
            end
            @(posedge i_clk);
            base_rise = rise_count;
            base_done = done_count;
            i_func <= code;
            t = 0;
            while (rise_count == base_rise && done_count == base_done && t < QUIET_CYCLES) begin
                @(posedge i_clk);
                t++;
            end
            check_value($sformatf("E pulses for code %0d", code), rise_count - base_rise, 0);
            check_value($sformatf("done pulses for code %0d", code), done_count - base_done, 0);
            @(posedge i_clk);
            i_func <= 4'hF;
        end
        end_test("unused function codes");

        // drop the enable while a data write still has E high
        take_bits(8, v);
        @(posedge i_clk);
        base_rise = rise_count;
        base_done = done_count;
        i_func <= lcd_pkg::FUNC_DATA;
        i_data <= v[7:0];
        wait_rises(base_rise + 1, OP_TIMEOUT, ok);
        if (!ok) begin
            errors++;
            $display("timeout: data write never raised E at %0t", $time);
        end
        i_en_lcd <= 1'b0;
        i_func   <= 4'hF;
        t = 0;
        @(negedge i_clk);
        while (o_lcd_e && t < 2) begin
            @(negedge i_clk);
            t++;
        end
        check_value("E low two cycles after enable dropped", 32'(o_lcd_e), 0);
        check_value("lcd_on follows enable", 32'(o_lcd_on), 0);
        t = 0;
        while (done_count == base_done && t < QUIET_CYCLES) begin
            @(posedge i_clk);
            t++;
        end
        check_value("done pulses after abort", done_count - base_done, 0);
        check_value("E pulses after abort", rise_count - base_rise, 1);
        @(posedge i_clk);
        i_en_lcd <= 1'b1;
        end_test("abort on enable low");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
            tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- lcd_ctrl/lcd_delay_timer.sv
module lcd_delay_timer #(
    parameter lcd_pkg::delay_t P_DLY_POWERUP    = 750000,
    parameter lcd_pkg::delay_t P_DLY_INIT_FIRST = 205000,
    parameter lcd_pkg::delay_t P_DLY_INIT_NEXT  = 5000,
    parameter lcd_pkg::delay_t P_DLY_EXEC       = 1850,
    parameter lcd_pkg::delay_t P_DLY_CLEAR      = 76000,
    parameter lcd_pkg::delay_t P_DLY_PULSE      = 12
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  lcd_pkg::delay_class_e   i_class,
    output logic                    o_expired
);

    lcd_pkg::delay_t    load_val;
    lcd_pkg::delay_t    cnt_q;
    logic               running_q;

    // class to cycle count
    always_comb begin
        case (i_class)
            lcd_pkg::DLY_POWERUP:    load_val = P_DLY_POWERUP;
            lcd_pkg::DLY_INIT_FIRST: load_val = P_DLY_INIT_FIRST;
            lcd_pkg::DLY_INIT_NEXT:  load_val = P_DLY_INIT_NEXT;
            lcd_pkg::DLY_CLEAR:      load_val = P_DLY_CLEAR;
            lcd_pkg::DLY_PULSE:      load_val = P_DLY_PULSE;
            default:                 load_val = P_DLY_EXEC;
        endcase
    end

    // cnt holds the cycles left, including the current one
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q     <= '0;
            running_q <= 1'b0;
        end else if (i_start) begin
            // restart wins over a running count
            cnt_q     <= load_val;
            running_q <= 1'b1;
        end else if (running_q) begin
            if (o_expired) begin
                running_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // last cycle of the count, a zero count behaves like one
    assign o_expired = running_q && (cnt_q <= lcd_pkg::delay_t'(1));

    // expiry needs a start or a running count one cycle back
    a_expire_after_start: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_expired |-> $past(running_q) || $past(i_start)
    );

endmodule

//--- lcd_ctrl/lcd_sequencer.sv
module lcd_sequencer (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_en_lcd,
    input  lcd_pkg::lcd_func_t          i_func,
    input  lcd_pkg::lcd_byte_t          i_data,
    output logic                        o_tmr_start,
    output lcd_pkg::delay_class_e       o_tmr_class,
    input  logic                        i_tmr_expired,
    output logic                        o_done_lcd,
    lcd_seq_if.seq                      bus
);

    typedef enum logic [2:0] {
        IDLE,
        POWERUP_WAIT,
        BYTE_SETUP,
        PULSE,
        POST_WAIT
    } state_e;

    state_e                 state_q;
    state_e                 state_d;
    lcd_pkg::lcd_func_t     func_q;
    lcd_pkg::lcd_byte_t     arg_q;
    lcd_pkg::init_step_t    step_q;
    logic                   req_valid;
    logic                   is_init;
    logic                   last_step;
    logic                   more_bytes;
    logic                   done_q;

    // only codes 0..3 start anything
    assign req_valid  = i_en_lcd && (i_func <= lcd_pkg::FUNC_DATA);
    assign is_init    = (func_q == lcd_pkg::FUNC_INIT);
    assign last_step  = (step_q == lcd_pkg::init_step_t'(lcd_pkg::INIT_CMD_COUNT - 1));
    // another init byte follows the current one
    assign more_bytes = is_init && !last_step;

    // wait after a byte depends on what was sent
    function automatic lcd_pkg::delay_class_e post_class(
        input lcd_pkg::lcd_func_t  func,
        input lcd_pkg::init_step_t step,
        input lcd_pkg::lcd_byte_t  arg
    );
        lcd_pkg::delay_class_e cls;
        cls = lcd_pkg::DLY_EXEC;
        if (func == lcd_pkg::FUNC_INIT) begin
            case (step)
                // first function set needs 4.1 ms
                3'd0: cls = lcd_pkg::DLY_INIT_FIRST;
                3'd1, 3'd2: cls = lcd_pkg::DLY_INIT_NEXT;
                // clear and return home in the table
                3'd4, 3'd5: cls = lcd_pkg::DLY_CLEAR;
                default: cls = lcd_pkg::DLY_EXEC;
            endcase
        end else if (func == lcd_pkg::FUNC_CMD) begin
            if (arg == lcd_pkg::CMD_CLEAR_DISPLAY || arg == lcd_pkg::CMD_RETURN_HOME) begin
                cls = lcd_pkg::DLY_CLEAR;
            end
        end
        return cls;
    endfunction

    // next state and timer requests
    always_comb begin
        state_d     = state_q;
        o_tmr_start = 1'b0;
        o_tmr_class = lcd_pkg::DLY_EXEC;
        case (state_q)
            IDLE: begin
                if (req_valid) begin
                    if (i_func == lcd_pkg::FUNC_INIT) begin
                        // power-up wait before the first byte
                        o_tmr_start = 1'b1;
                        o_tmr_class = lcd_pkg::DLY_POWERUP;
                        state_d     = POWERUP_WAIT;
                    end else begin
                        state_d = BYTE_SETUP;
                    end
                end
            end
            POWERUP_WAIT: begin
                if (i_tmr_expired) begin
                    state_d = BYTE_SETUP;
                end
            end
            BYTE_SETUP: begin
                // byte goes out now and the E pulse is timed from here
                o_tmr_start = 1'b1;
                o_tmr_class = lcd_pkg::DLY_PULSE;
                state_d     = PULSE;
            end
            PULSE: begin
                if (i_tmr_expired) begin
                    o_tmr_start = 1'b1;
                    o_tmr_class = post_class(func_q, step_q, arg_q);
                    state_d     = POST_WAIT;
                end
            end
            POST_WAIT: begin
                if (i_tmr_expired) begin
                    state_d = more_bytes ? BYTE_SETUP : IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // dropping the enable aborts whatever runs
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
        end else if (!i_en_lcd) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request latch only taken when leaving idle
    always_ff @(posedge i_clk) begin
        if (state_q == IDLE && req_valid) begin
            func_q <= i_func;
            arg_q  <= i_data;
        end
    end

    // init step is cleared in idle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            step_q <= '0;
        end else if (state_q == IDLE) begin
            step_q <= '0;
        end else if (state_q == POST_WAIT && i_tmr_expired && more_bytes) begin
            step_q <= step_q + 1'b1;
        end
    end

    // done lands in the first idle cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= i_en_lcd && (state_q == POST_WAIT) && i_tmr_expired && !more_bytes;
        end
    end

    assign o_done_lcd = done_q;

    // request type to byte source
    always_comb begin
        case (func_q)
            lcd_pkg::FUNC_INIT:      bus.src = lcd_pkg::SRC_INIT;
            lcd_pkg::FUNC_SETCURSOR: bus.src = lcd_pkg::SRC_CURSOR;
            lcd_pkg::FUNC_CMD:       bus.src = lcd_pkg::SRC_CMD;
            default:                 bus.src = lcd_pkg::SRC_DATA;
        endcase
    end

    assign bus.load   = (state_q == BYTE_SETUP);
    assign bus.e_high = (state_q == PULSE);
    assign bus.step   = step_q;
    assign bus.arg    = arg_q;

    // table index holds still for the whole E pulse
    a_step_in_pulse: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (state_q == PULSE) && $past(state_q == PULSE) |-> $stable(step_q)
    );

endmodule

//--- project.f
+incdir+dv
common/lcd_pkg.sv
common/lcd_seq_if.sv
lcd_ctrl/lcd_delay_timer.sv
lcd_ctrl/lcd_sequencer.sv
src/lcd_bus_driver.sv
src/lcd_ctrl_top.sv
dv/tb_lcd_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the fail line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_lcd_ctrl -f project.f -o sim_lcd \
    && ./obj_dir/sim_lcd > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

//--- src/lcd_bus_driver.sv
module lcd_bus_driver (
    input  logic                i_clk,
    input  logic                i_rst_n,
    lcd_seq_if.drv              bus,
    output lcd_pkg::lcd_byte_t  o_lcd_data,
    output logic                o_lcd_rs,
    output logic                o_lcd_e
);

    lcd_pkg::lcd_byte_t byte_d;
    lcd_pkg::lcd_byte_t data_q;
    logic               rs_q;
    logic               e_q;

    // power-up command table
    function automatic lcd_pkg::lcd_byte_t init_byte(input lcd_pkg::init_step_t step);
        lcd_pkg::lcd_byte_t b;
        case (step)
            // function set sent three times
            3'd0, 3'd1, 3'd2: b = lcd_pkg::CMD_FUNCTION_SET;
            3'd3: b = lcd_pkg::CMD_DISPLAY_OFF;
            3'd4: b = lcd_pkg::CMD_CLEAR_DISPLAY;
            3'd5: b = lcd_pkg::CMD_RETURN_HOME;
            3'd6: b = lcd_pkg::CMD_ENTRY_INCREASE;
            default: b = lcd_pkg::CMD_DISPLAY_ON;
        endcase
        return b;
    endfunction

    // upper nibble picks the line, lower nibble the column
    function automatic lcd_pkg::lcd_byte_t cursor_byte(input lcd_pkg::lcd_byte_t arg);
        lcd_pkg::lcd_byte_t b;
        case (arg[7:4])
            4'h0: b = lcd_pkg::CMD_LINE_1 + {4'h0, arg[3:0]};
            4'h1: b = lcd_pkg::CMD_LINE_2 + {4'h0, arg[3:0]};
            // out of range, home of line 1
            default: b = lcd_pkg::CMD_LINE_1;
        endcase
        return b;
    endfunction

    // byte formed from the source
    always_comb begin
        case (bus.src)
            lcd_pkg::SRC_INIT:   byte_d = init_byte(bus.step);
            lcd_pkg::SRC_CURSOR: byte_d = cursor_byte(bus.arg);
            default:             byte_d = bus.arg;
        endcase
    end

    // data and rs held until the next load
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            data_q <= '0;
            rs_q   <= 1'b0;
        end else if (bus.load) begin
            data_q <= byte_d;
            // rs high selects the data register
            rs_q   <= (bus.src == lcd_pkg::SRC_DATA);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            e_q <= 1'b0;
        end else begin
            e_q <= bus.e_high;
        end
    end

    assign o_lcd_data = data_q;
    assign o_lcd_rs   = rs_q;
    assign o_lcd_e    = e_q;

    // bus must be settled before E goes up
    a_load_not_during_e: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(bus.load && bus.e_high)
    );

endmodule

//--- src/lcd_ctrl_top.sv
module lcd_ctrl_top #(
    parameter lcd_pkg::delay_t P_DLY_POWERUP    = 750000,
    parameter lcd_pkg::delay_t P_DLY_INIT_FIRST = 205000,
    parameter lcd_pkg::delay_t P_DLY_INIT_NEXT  = 5000,
    parameter lcd_pkg::delay_t P_DLY_EXEC       = 1850,
    parameter lcd_pkg::delay_t P_DLY_CLEAR      = 76000,
    parameter lcd_pkg::delay_t P_DLY_PULSE      = 12
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_en_lcd,
    input  logic                i_lcd_blon,
    input  lcd_pkg::lcd_byte_t  i_data,
    input  lcd_pkg::lcd_func_t  i_func,
    output lcd_pkg::lcd_byte_t  o_lcd_data,
    output logic                o_lcd_e,
    output logic                o_lcd_rw,
    output logic                o_lcd_rs,
    output logic                o_lcd_on,
    output logic                o_lcd_blon,
    output logic                o_done_lcd
);

    // sequencer to timer
    logic                   tmr_start;
    lcd_pkg::delay_class_e  tmr_class;
    logic                   tmr_expired;

    lcd_seq_if u_seq_if ();

    lcd_sequencer u_sequencer (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_en_lcd      (i_en_lcd),
        .i_func        (i_func),
        .i_data        (i_data),
        .o_tmr_start   (tmr_start),
        .o_tmr_class   (tmr_class),
        .i_tmr_expired (tmr_expired),
        .o_done_lcd    (o_done_lcd),
        .bus           (u_seq_if.seq)
    );

    lcd_delay_timer #(
        .P_DLY_POWERUP    (P_DLY_POWERUP),
        .P_DLY_INIT_FIRST (P_DLY_INIT_FIRST),
        .P_DLY_INIT_NEXT  (P_DLY_INIT_NEXT),
        .P_DLY_EXEC       (P_DLY_EXEC),
        .P_DLY_CLEAR      (P_DLY_CLEAR),
        .P_DLY_PULSE      (P_DLY_PULSE)
    ) u_delay_timer (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_start   (tmr_start),
        .i_class   (tmr_class),
        .o_expired (tmr_expired)
    );

    lcd_bus_driver u_bus_driver (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .bus        (u_seq_if.drv),
        .o_lcd_data (o_lcd_data),
        .o_lcd_rs   (o_lcd_rs),
        .o_lcd_e    (o_lcd_e)
    );

    // write only, never reads busy flag
    assign o_lcd_rw   = 1'b0;
    // display power follows the enable, backlight passes straight through
    assign o_lcd_on   = i_en_lcd;
    assign o_lcd_blon = i_lcd_blon;

endmodule
